//--- source/cpu_consts.svh
/*
 * CPU constants
 * Widths, register map, reset vector and Avalon encodings of the core
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width
`define CPU_XLEN 32

// General register file
`define CPU_NREGS 32
`define CPU_REG_V0 2

// First fetch after reset
`define CPU_RESET_VECTOR 32'hBFC00000

// Reaching this PC stops the core
`define CPU_HALT_ADDR 32'h00000000

// Word access, all byte lanes on
`define CPU_BE_WORD 4'b1111

`endif

//--- source/cpu_pkg.sv
/*
 * CPU types
 * Instruction encodings, ALU operations and the structs passed between blocks
 */
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

    // Primary opcodes of the subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASS_B
    } alu_op_t;

    // How the 16-bit immediate becomes operand B
    typedef enum logic [1:0] {
        IMM_SIGN,
        IMM_ZERO,
        IMM_NONE
    } imm_kind_t;

    // PC update kind
    typedef enum logic [2:0] {
        FLOW_NEXT,
        FLOW_BEQ,
        FLOW_BNE,
        FLOW_JUMP,
        FLOW_JREG
    } flow_t;

    typedef struct packed {
        alu_op_t    alu_op;
        imm_kind_t  imm_kind;
        logic [4:0] dest;
        logic       reg_write;
        logic       is_load;
        logic       is_store;
        flow_t      flow;
    } ctrl_t;

    // Avalon master request, unpacked at the top level
    typedef struct packed {
        logic [`CPU_XLEN-1:0]   address;
        logic                   read;
        logic                   write;
        logic [`CPU_XLEN-1:0]   writedata;
        logic [`CPU_XLEN/8-1:0] byteenable;
    } bus_req_t;

    typedef struct packed {
        logic                 enable;
        logic [4:0]           index;
        logic [`CPU_XLEN-1:0] data;
    } rf_write_t;

endpackage

`default_nettype wire

//--- source/instr_decoder.sv
/*
 * Instruction decoder
 * Maps an instruction word onto the control struct of the execute stage
 */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import cpu_pkg::*; (
    input  logic [31:0] instr,
    output ctrl_t       ctrl
);

    opcode_t    opcode;
    funct_t     funct;
    logic [4:0] rt;
    logic [4:0] rd;

    // Field split
    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        // Unknown encodings fall through as a no-op
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.imm_kind  = IMM_NONE;
        ctrl.dest      = rd;
        ctrl.reg_write = 1'b0;
        ctrl.is_load   = 1'b0;
        ctrl.is_store  = 1'b0;
        ctrl.flow      = FLOW_NEXT;

        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_XOR:  ctrl.alu_op = ALU_XOR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_SLTU: ctrl.alu_op = ALU_SLTU;
                    FN_SLL:  ctrl.alu_op = ALU_SLL;
                    FN_SRL:  ctrl.alu_op = ALU_SRL;
                    FN_SRA:  ctrl.alu_op = ALU_SRA;
                    FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.flow      = FLOW_JREG;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            // Immediate ALU ops write rt
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.dest      = rt;
                ctrl.reg_write = 1'b1;
                ctrl.imm_kind  = (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) ?
                                 IMM_ZERO : IMM_SIGN;
                case (opcode)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctrl.alu_op = ALU_AND;
                    OP_ORI:   ctrl.alu_op = ALU_OR;
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_LUI:   ctrl.alu_op = ALU_LUI;
                    default:  ctrl.alu_op = ALU_ADD;
                endcase
            end
            // Address is base plus signed offset
            OP_LW: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.imm_kind  = IMM_SIGN;
                ctrl.dest      = rt;
                ctrl.reg_write = 1'b1;
                ctrl.is_load   = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_op   = ALU_ADD;
                ctrl.imm_kind = IMM_SIGN;
                ctrl.is_store = 1'b1;
            end
            OP_BEQ: ctrl.flow = FLOW_BEQ;
            OP_BNE: ctrl.flow = FLOW_BNE;
            OP_J:   ctrl.flow = FLOW_JUMP;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu.sv
/*
 * ALU
 * Add, subtract, logic, set-less-than, immediate shifts and LUI
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
    input  alu_op_t              op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  logic [4:0]           shamt,
    output logic [`CPU_XLEN-1:0] result
);

    logic lt_signed;
    logic lt_unsigned;

    // Compare results, zero-extended below
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            // Shifts act on rt, amount from the instruction
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            // Immediate into the upper half
            ALU_LUI:  result = {b[15:0], 16'h0000};
            ALU_PASS_B: result = b;
            default:  result = b;
        endcase
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
/*
 * Register file
 * 32 general registers, two read ports, one write port, v0 tap
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module register_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [4:0]           rs_idx,
    input  logic [4:0]           rt_idx,
    output logic [`CPU_XLEN-1:0] rs_val,
    output logic [`CPU_XLEN-1:0] rt_val,
    input  rf_write_t            wr,
    output logic [`CPU_XLEN-1:0] v0
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // Register zero is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.enable && wr.index != 5'd0) begin
            regs[wr.index] <= wr.data;
        end
    end

    // Asynchronous reads
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];
    assign v0     = regs[`CPU_REG_V0];

endmodule

`default_nettype wire

//--- source/exec_controller.sv
/*
 * Execute controller
 * Multicycle fetch/execute/memory sequencer with the PC, the instruction
 * register and the Avalon master request
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module exec_controller import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    output logic [31:0]          instr,
    input  ctrl_t                ctrl,
    output logic [4:0]           rs_idx,
    output logic [4:0]           rt_idx,
    input  logic [`CPU_XLEN-1:0] rs_val,
    input  logic [`CPU_XLEN-1:0] rt_val,
    output logic [`CPU_XLEN-1:0] alu_a,
    output logic [`CPU_XLEN-1:0] alu_b,
    output logic [4:0]           shamt,
    output alu_op_t              alu_op,
    input  logic [`CPU_XLEN-1:0] alu_result,
    output rf_write_t            rf_wr,
    output bus_req_t             bus_req,
    input  logic                 waitrequest,
    input  logic [`CPU_XLEN-1:0] readdata,
    output logic                 active
);

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_HALT
    } state_t;

    state_t               state;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] ir;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] imm_sext;
    logic [`CPU_XLEN-1:0] next_pc;
    logic                 at_halt;
    logic                 mem_op;

    // Instruction fields
    assign instr  = ir;
    assign rs_idx = ir[25:21];
    assign rt_idx = ir[20:16];
    assign shamt  = ir[10:6];

    assign imm_sext = {{(`CPU_XLEN-16){ir[15]}}, ir[15:0]};
    assign pc_plus4 = pc + `CPU_XLEN'd4;
    assign at_halt  = (pc == `CPU_HALT_ADDR);
    assign mem_op   = ctrl.is_load | ctrl.is_store;
    assign active   = (state != ST_HALT);

    // Operand A is always rs; B is rt or the extended immediate
    assign alu_a  = rs_val;
    assign alu_op = ctrl.alu_op;
    always_comb begin
        case (ctrl.imm_kind)
            IMM_SIGN: alu_b = imm_sext;
            IMM_ZERO: alu_b = {{(`CPU_XLEN-16){1'b0}}, ir[15:0]};
            default:  alu_b = rt_val;
        endcase
    end

    // Branch target is relative to PC+4, no delay slot
    always_comb begin
        next_pc = pc_plus4;
        case (ctrl.flow)
            FLOW_BEQ: begin
                if (rs_val == rt_val) next_pc = pc_plus4 + {imm_sext[`CPU_XLEN-3:0], 2'b00};
            end
            FLOW_BNE: begin
                if (rs_val != rt_val) next_pc = pc_plus4 + {imm_sext[`CPU_XLEN-3:0], 2'b00};
            end
            FLOW_JUMP: next_pc = {pc_plus4[31:28], ir[25:0], 2'b00};
            FLOW_JREG: next_pc = rs_val;
            default:   next_pc = pc_plus4;
        endcase
    end

    // Request is decoded from state, so it holds while waitrequest is high
    always_comb begin
        bus_req.address    = pc;
        bus_req.read       = 1'b0;
        bus_req.write      = 1'b0;
        bus_req.writedata  = '0;
        bus_req.byteenable = `CPU_BE_WORD;
        case (state)
            ST_FETCH: bus_req.read = !at_halt;
            ST_MEM: begin
                bus_req.address   = alu_result;
                bus_req.read      = ctrl.is_load;
                bus_req.write     = ctrl.is_store;
                bus_req.writedata = ctrl.is_store ? rt_val : '0;
            end
            default: ;
        endcase
    end

    // ALU results land in EXEC, load data when the read completes
    assign rf_wr.enable = (state == ST_EXEC && ctrl.reg_write && !ctrl.is_load) ||
                          (state == ST_MEM && ctrl.is_load && !waitrequest);
    assign rf_wr.index  = ctrl.dest;
    assign rf_wr.data   = (state == ST_MEM) ? readdata : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
            pc    <= `CPU_RESET_VECTOR;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (at_halt) state <= ST_HALT;
                    else if (!waitrequest) state <= ST_EXEC;
                end
                ST_EXEC: begin
                    pc    <= next_pc;
                    state <= mem_op ? ST_MEM : ST_FETCH;
                end
                ST_MEM: begin
                    if (!waitrequest) state <= ST_FETCH;
                end
                ST_HALT: state <= ST_HALT;
            endcase
        end
    end

    // Latch the fetched word on transfer completion
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && !at_halt && !waitrequest) begin
            ir <= readdata;
        end
    end

endmodule

`default_nettype wire

//--- source/mips_cpu_bus.sv
/*
 * MIPS CPU, Avalon bus variant
 * Ties controller, decoder, ALU and register file to the master port
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module mips_cpu_bus import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   active,
    output logic [`CPU_XLEN-1:0]   register_v0,
    output logic [`CPU_XLEN-1:0]   address,
    output logic                   read,
    output logic                   write,
    output logic [`CPU_XLEN-1:0]   writedata,
    output logic [`CPU_XLEN/8-1:0] byteenable,
    input  logic                   waitrequest,
    input  logic [`CPU_XLEN-1:0]   readdata
);

    logic [31:0]          instr;
    ctrl_t                ctrl;
    logic [4:0]           rs_idx;
    logic [4:0]           rt_idx;
    logic [`CPU_XLEN-1:0] rs_val;
    logic [`CPU_XLEN-1:0] rt_val;
    logic [`CPU_XLEN-1:0] alu_a;
    logic [`CPU_XLEN-1:0] alu_b;
    logic [4:0]           shamt;
    alu_op_t              alu_op;
    logic [`CPU_XLEN-1:0] alu_result;
    rf_write_t            rf_wr;
    bus_req_t             bus_req;

    exec_controller i_exec_controller (
        .clk, .reset, .instr, .ctrl, .rs_idx, .rt_idx, .rs_val, .rt_val,
        .alu_a, .alu_b, .shamt, .alu_op, .alu_result, .rf_wr, .bus_req,
        .waitrequest, .readdata, .active
    );

    instr_decoder i_instr_decoder (.instr, .ctrl);

    alu i_alu (.op(alu_op), .a(alu_a), .b(alu_b), .shamt, .result(alu_result));

    register_file i_register_file (
        .clk, .reset, .rs_idx, .rt_idx, .rs_val, .rt_val, .wr(rf_wr), .v0(register_v0)
    );

    // Avalon pins
    assign address    = bus_req.address;
    assign read       = bus_req.read;
    assign write      = bus_req.write;
    assign writedata  = bus_req.writedata;
    assign byteenable = bus_req.byteenable;

endmodule

`default_nettype wire

//--- test/avalon_memory.sv
/*
 * Avalon slave memory model
 * Word-addressed store with random waitrequest and a log of completed writes
 */
`timescale 1ns/1ps
`default_nettype none

module avalon_memory #(
    parameter int unsigned MAX_WAIT = 3,
    parameter logic [31:0] SEED     = 32'h775b70ef
) (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    logic [31:0] words [logic [29:0]];
    // Completed writes as {address, data, byteenable}
    logic [67:0] write_log [$];
    int unsigned wait_run;
    logic        stall;

    // Unwritten words, different for every address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5AA5A5;
    endfunction

    function automatic logic [31:0] lookup(input logic [31:0] addr);
        return words.exists(addr[31:2]) ? words[addr[31:2]] : fill_word(addr);
    endfunction

    task automatic clear();
        words.delete();
        write_log.delete();
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data);
        words[addr[31:2]] = data;
    endtask

    task automatic pop_write(output logic [31:0] addr, output logic [31:0] data,
                             output logic [3:0] be, output logic found);
        logic [67:0] entry;
        entry = '0;
        found = (write_log.size() != 0);
        if (found) entry = write_log.pop_front();
        {addr, data, be} = entry;
    endtask

    // Slave outputs change just after the rising edge
    initial begin
        void'($urandom(SEED));
        waitrequest = 1'b1;
        readdata    = '0;
        wait_run    = 0;
        forever begin
            @(posedge clk);
            #1;
            // Stall about half the cycles, never more than MAX_WAIT in a row
            stall       = ($urandom % 2) == 1 && wait_run < MAX_WAIT;
            wait_run    = stall ? wait_run + 1 : 0;
            waitrequest = stall;
            if (read === 1'b1) readdata = lookup(address);
        end
    end

    // Write completes in a cycle with waitrequest low
    always @(negedge clk) begin
        if (write === 1'b1 && waitrequest === 1'b0) begin
            words[address[31:2]] = writedata;
            write_log.push_back({address, writedata, byteenable});
        end
    end

endmodule

`default_nettype wire

//--- test/tb_mips_cpu_bus.sv
/*
 * Testbench for the Avalon MIPS CPU
 * Runs small programs from the reset vector and checks v0, stores and bus rules
 */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_mips_cpu_bus;

    localparam int CLK_PERIOD   = 100;
    localparam int N_TESTS      = 4;
    localparam int INSTR_BUDGET = 64;
    localparam int MAX_WAIT     = 3;
    localparam int HALT_SPAN    = 16;
    // Fetch and memory phase may each stall MAX_WAIT cycles
    localparam int CYCLES_PER_INSTR = 3 + 2 * MAX_WAIT;
    localparam int RUN_LIMIT        = INSTR_BUDGET * CYCLES_PER_INSTR;
    localparam int TEST_CYCLES      = RUN_LIMIT + HALT_SPAN + 16;

    // MIPS encodings
    localparam int ADDIU = 9, SLTI = 10, SLTIU = 11, ANDI = 12, ORI = 13;
    localparam int XORI = 14, LUI = 15, LW = 35, SW = 43, BEQ = 4, BNE = 5;
    localparam int SLL = 0, SRL = 2, SRA = 3, JR = 8, ADDU = 33, SUBU = 35;
    localparam int XOR = 38, SLT = 42, SLTU = 43;
    localparam int ZERO = 0, V0 = 2, T0 = 8, T1 = 9, T2 = 10, T3 = 11;
    localparam int T4 = 12, T5 = 13, T6 = 14, T7 = 15, S0 = 16, S1 = 17, RA = 31;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        waitrequest;
    logic [31:0] readdata;

    int          errors;
    int          test_base;
    int          tests_run;
    int          tests_failed;
    logic [31:0] prog [$];

    mips_cpu_bus i_mips_cpu_bus (
        .clk, .reset, .active, .register_v0, .address, .read, .write,
        .writedata, .byteenable, .waitrequest, .readdata
    );

    avalon_memory #(.MAX_WAIT(MAX_WAIT)) i_avalon_memory (
        .clk, .address, .read, .write, .writedata, .byteenable, .waitrequest, .readdata
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    // Avalon master rules
    assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable({address, read, write, writedata, byteenable}))
    else begin
        errors++;
        $display("Bus request changed while waitrequest was high at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (reset) !(read && write))
    else begin
        errors++;
        $display("Read and write were high together at %0t", $time);
    end

    // Once halted, the core stays quiet
    assert property (@(posedge clk) disable iff (reset)
        !active |=> !active && !read && !write)
    else begin
        errors++;
        $display("Bus activity or active high after halt at %0t", $time);
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] rtype(input int rs, input int rt, input int rd,
                                          input int sh, input int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] itype(input int op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] jump_to(input logic [31:0] target);
        return {6'd2, target[27:2]};
    endfunction

    task automatic put(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic start_test();
        @(posedge clk);
        #1;
        reset = 1'b1;
        i_avalon_memory.clear();
        prog.delete();
        test_base = errors;
    endtask

    // Load, release reset, wait for halt, then watch the idle bus
    task automatic run_program(input string name, input logic [31:0] exp_v0);
        int cycles;
        cycles = 0;
        foreach (prog[i]) i_avalon_memory.store(`CPU_RESET_VECTOR + 32'(4 * i), prog[i]);
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        compare("read", 32'd1, 32'(read));
        compare("write", 32'd0, 32'(write));
        compare("address", `CPU_RESET_VECTOR, address);
        while (active === 1'b1 && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (active === 1'b0) else begin
            errors++;
            $display("Program %s did not halt within %0d cycles", name, cycles);
        end
        compare("register_v0", exp_v0, register_v0);
        repeat (HALT_SPAN) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("%-8s ok", name);
        end else begin
            tests_failed++;
            $display("%-8s %0d error(s)", name, errors - test_base);
        end
    endtask

    task automatic expect_store(input logic [31:0] exp_addr, input logic [31:0] exp_data);
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic        found;
        i_avalon_memory.pop_write(addr, data, be, found);
        assert (found) else begin
            errors++;
            $display("Store to %h never reached the bus", exp_addr);
        end
        if (found) begin
            compare("address", exp_addr, addr);
            compare("writedata", exp_data, data);
            compare("byteenable", 32'(`CPU_BE_WORD), 32'(be));
        end
    endtask

    task automatic arith_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] v;
        start_test();
        put(itype(ADDIU, ZERO, T0, 16'h1234));
        put(itype(LUI, ZERO, T1, 16'h8765));
        put(itype(ORI, T1, T1, 16'h4321));
        put(itype(ANDI, T1, T2, 16'hFF0F));
        put(itype(XORI, T2, T2, 16'hFFFF));
        put(rtype(T1, T0, V0, 0, SUBU));
        put(rtype(T1, T0, T3, 0, SLT));
        put(rtype(T1, T0, T4, 0, SLTU));
        put(itype(SLTI, T0, T5, 16'hFFFF));
        put(itype(SLTIU, T0, T6, 16'hFFFF));
        put(rtype(ZERO, T1, T7, 4, SLL));
        put(rtype(ZERO, T1, S0, 8, SRL));
        put(rtype(ZERO, T1, S1, 8, SRA));
        // $zero swallows this write
        put(itype(ADDIU, ZERO, ZERO, 16'h0005));
        put(rtype(V0, T2, V0, 0, XOR));
        // Shift each compare flag into v0
        for (int r = T3; r <= T6; r++) begin
            put(rtype(V0, V0, V0, 0, ADDU));
            put(rtype(V0, r, V0, 0, ADDU));
        end
        put(rtype(V0, T7, V0, 0, XOR));
        put(rtype(V0, S0, V0, 0, XOR));
        put(rtype(V0, S1, V0, 0, SUBU));
        put(rtype(V0, ZERO, V0, 0, ADDU));
        put(rtype(RA, 0, 0, 0, JR));
        a = 32'h0000_1234;
        b = 32'h8765_0000 | 32'h0000_4321;
        c = (b & 32'h0000_FF0F) ^ 32'h0000_FFFF;
        d = $signed(b) >>> 8;
        v = (b - a) ^ c;
        v = 2 * v + 32'($signed(b) < $signed(a));
        v = 2 * v + 32'(b < a);
        v = 2 * v + 32'($signed(a) < -1);
        v = 2 * v + 32'(a < 32'hFFFF_FFFF);
        v = v ^ (b << 4) ^ (b >> 8);
        v = v - d;
        run_program("arith", v);
        report_test("arith");
    endtask

    task automatic store_test();
        logic [31:0] base;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic        found;
        start_test();
        base = 32'h1000_0100;
        put(itype(LUI, ZERO, T0, 16'h1000));
        put(itype(ADDIU, T0, T0, 16'h0100));
        put(itype(LUI, ZERO, T1, 16'hCAFE));
        put(itype(ORI, T1, T1, 16'hBABE));
        put(itype(SW, T0, T1, 16'hFFF8));
        put(itype(SW, T0, T0, 16'h000C));
        put(itype(ADDIU, ZERO, V0, 16'h0007));
        put(rtype(RA, 0, 0, 0, JR));
        run_program("store", 32'h0000_0007);
        expect_store(base - 32'd8, 32'hCAFE_BABE);
        expect_store(base + 32'd12, base);
        i_avalon_memory.pop_write(addr, data, be, found);
        assert (!found) else begin
            errors++;
            $display("Unexpected extra store to %h", addr);
        end
        report_test("store");
    endtask

    task automatic load_test();
        start_test();
        i_avalon_memory.store(32'h1000_0040, 32'h1357_2468);
        put(itype(LUI, ZERO, T0, 16'h1000));
        put(itype(ORI, T0, T0, 16'h0080));
        put(itype(ADDIU, ZERO, T2, 16'h7FF0));
        // Negative offset reaches back to the preloaded word
        put(itype(LW, T0, T1, 16'hFFC0));
        put(rtype(T1, T2, V0, 0, ADDU));
        put(rtype(RA, 0, 0, 0, JR));
        run_program("load", 32'h1357_2468 + 32'h0000_7FF0);
        report_test("load");
    endtask

    task automatic branch_test();
        start_test();
        put(itype(ADDIU, ZERO, V0, 16'h0001));
        put(itype(ADDIU, ZERO, T0, 16'h0005));
        put(itype(ADDIU, ZERO, T1, 16'h0005));
        put(itype(BEQ, T0, T1, 16'h0001));
        put(itype(ADDIU, V0, V0, 16'h0100));
        put(itype(BNE, T0, T1, 16'h0001));
        put(itype(ADDIU, V0, V0, 16'h0010));
        put(jump_to(`CPU_RESET_VECTOR + 32'd36));
        put(itype(ADDIU, V0, V0, 16'h1000));
        put(itype(ADDIU, V0, V0, 16'h0002));
        put(rtype(RA, 0, 0, 0, JR));
        // Only the BNE fall-through and the jump target add to v0
        run_program("branch", 32'h0000_0013);
        report_test("branch");
    endtask

    initial begin
        reset        = 1'b1;
        errors       = 0;
        test_base    = 0;
        tests_run    = 0;
        tests_failed = 0;
        arith_test();
        store_test();
        load_test();
        branch_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/cpu_pkg.sv
source/instr_decoder.sv
source/alu.sv
source/register_file.sv
source/exec_controller.sv
source/mips_cpu_bus.sv
test/avalon_memory.sv
test/tb_mips_cpu_bus.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_mips_cpu_bus --Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
